// File: sms_settings.svh
//==========================================================================
// Master System host glue settings
// Divider period, bus widths, copier header, backup size and loader indices
//==========================================================================
`ifndef SMS_SETTINGS_SVH
`define SMS_SETTINGS_SVH

// Clock enable divider
`define SMS_CE_PERIOD 30        // clk_sys cycles per enable frame
`define SMS_CE_CW     5         // Divider counter width

// Address widths
`define SMS_ROM_AW    22        // ROM byte address
`define SMS_IOCTL_AW  25        // Loader address

// Copier header prepended to some dumps
`define SMS_HDR_BYTES 512

// Backup RAM image in 512-byte sectors
`define SMS_BK_SECTORS 64

// Loader indices
`define SMS_CHEAT_INDEX 8'hFF   // Cheat file download
`define SMS_GG_INDEX    5'd2    // Game Gear cartridge, low five bits

`endif

// File: sms_pkg.sv
//==========================================================================
// Master System host glue types
// Backup sequencer state and the cheat record layout
//==========================================================================
package sms_pkg;

	// Backup RAM sequencer
	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_LOAD = 2'd1,         // Sectors SD -> NVRAM
		BK_SAVE = 2'd2          // Sectors NVRAM -> SD
	} bk_state_e;

	//======================================================================
	// Cheat record, 128 bits
	//======================================================================
	// Each word is built least significant byte first by the loader
	typedef struct packed {
		logic [31:0] flags;     // Bits 127:96
		logic [31:0] addr;      // Bits 95:64
		logic [31:0] compare;   // Bits 63:32
		logic [31:0] replace;   // Bits 31:0
	} cheat_code_t;

endpackage

// File: sms_ce_gen.sv
`timescale 1ns/1ps
//==========================================================================
// Clock enable generator
// Divides clk_sys into the CPU, VDP, pixel and sprite strobes
//==========================================================================
`include "sms_settings.svh"

module sms_ce_gen
	import sms_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam logic [`SMS_CE_CW-1:0] cnt_last = `SMS_CE_PERIOD - 1;

	logic [`SMS_CE_CW-1:0] clk_div;

	// Strobes are decoded from the count and land one cycle later
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_div <= '0;
			ce_cpu  <= 1'b0;
			ce_vdp  <= 1'b0;
			ce_pix  <= 1'b0;
			ce_sp   <= 1'b0;
		end else begin
			ce_sp  <= clk_div[0];       // Half rate
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;

			if (clk_div == cnt_last) clk_div <= '0;
			else clk_div <= clk_div + 1'b1;

			case (clk_div)
				`SMS_CE_CW'd4, `SMS_CE_CW'd14: begin
					ce_vdp <= 1'b1;
				end
				`SMS_CE_CW'd9: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
					ce_cpu <= 1'b1;
				end
				`SMS_CE_CW'd19, `SMS_CE_CW'd29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				`SMS_CE_CW'd24: begin // CPU phase shifted off the pixel strobe
					ce_vdp <= 1'b1;
					ce_cpu <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// CPU strobe sits on a VDP strobe and repeats every half frame
	a_cpu_on_vdp: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_cpu |-> ce_vdp);
	a_cpu_spacing: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_cpu |=> !ce_cpu [*(`SMS_CE_PERIOD / 2 - 1)] ##1 ce_cpu);

endmodule

// File: sms_cart_loader.sv
`timescale 1ns/1ps
//==========================================================================
// Cartridge loader
// Writes downloaded ROM bytes over a toggle handshake, builds the size
// masks and folds core read addresses into the loaded image
//==========================================================================
`include "sms_settings.svh"

module sms_cart_loader
	import sms_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     cart_download,
	input  logic                     ioctl_wr,
	input  logic [`SMS_IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]               ioctl_index,
	input  logic [7:0]               ioctl_dout,
	input  logic                     rom_ack,
	input  logic [`SMS_ROM_AW-1:0]   rd_addr,
	output logic                     ioctl_wait,
	output logic                     rom_wr,
	output logic [`SMS_ROM_AW-1:0]   rom_addr,
	output logic [7:0]               rom_data,
	output logic [`SMS_ROM_AW-1:0]   rd_addr_out,
	output logic                     is_gg
);

	localparam logic [`SMS_ROM_AW-1:0]   hdr_rom   = `SMS_HDR_BYTES;
	localparam logic [`SMS_IOCTL_AW-1:0] hdr_ioctl = `SMS_HDR_BYTES;
	localparam int unsigned              hdr_bit   = $clog2(`SMS_HDR_BYTES);

	logic                   dl_q;
	logic                   cart_wr;
	logic [`SMS_ROM_AW-1:0] wr_offs;
	logic [`SMS_ROM_AW-1:0] cart_mask;
	logic [`SMS_ROM_AW-1:0] cart_mask512;
	logic                   has_header;

	assign cart_wr = ioctl_wr & cart_download;
	assign wr_offs = ioctl_addr[`SMS_ROM_AW-1:0];

	//======================================================================
	// Write handshake
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q       <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			rom_addr   <= '0;
			rom_data   <= '0;
		end else begin
			dl_q <= cart_download;
			if (cart_download && !dl_q) begin
				rom_addr <= '0;             // New image
			end else if (cart_wr) begin
				rom_wr     <= ~rom_wr;      // Request toggle
				rom_data   <= ioctl_dout;
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_ack == rom_wr)) begin
				ioctl_wait <= 1'b0;
				rom_addr   <= rom_addr + 1'b1;
			end
		end
	end

	// Size masks, plain and header-offset
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_mask    <= '0;
			cart_mask512 <= '0;
			has_header   <= 1'b0;
			is_gg        <= 1'b0;
		end else begin
			if (cart_wr) begin
				cart_mask    <= cart_mask | wr_offs;
				cart_mask512 <= cart_mask512 | (wr_offs - hdr_rom);
				if (ioctl_addr == '0) cart_mask <= '0;
				if (ioctl_addr == hdr_ioctl) cart_mask512 <= '0;
				is_gg <= (ioctl_index[4:0] == `SMS_GG_INDEX);
			end
			// Final loader address is the image size
			if (dl_q && !cart_download) has_header <= ioctl_addr[hdr_bit];
		end
	end

	// Skip the copier header when one is present
	assign rd_addr_out = has_header ? ((rd_addr + hdr_rom) & cart_mask512)
	                                : (rd_addr & cart_mask);

	// Source honours back-pressure
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr);

endmodule

// File: sms_cheat_loader.sv
`timescale 1ns/1ps
//==========================================================================
// Cheat code loader
// Collects 16 downloaded bytes into one cheat record and strobes it out
//==========================================================================

module sms_cheat_loader
	import sms_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        code_download,
	input  logic        ioctl_wr,
	input  logic [3:0]  ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output cheat_code_t code,
	output logic        code_valid
);

	logic        code_wr;
	logic [15:0][7:0] rec;      // Byte 15 is the top of the flags word
	logic [3:0]  slot;

	assign code_wr = code_download & ioctl_wr;

	// Field n/4 from the top, byte n mod 4 from the bottom
	assign slot = {~ioctl_addr[3:2], ioctl_addr[1:0]};

	//======================================================================
	// Record assembly
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rec        <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (code_wr) begin
				rec[slot] <= ioctl_dout;
				if (&ioctl_addr) code_valid <= 1'b1;   // Last byte of the record
			end
		end
	end

	assign code = cheat_code_t'(rec);

endmodule

// File: sms_backup_ctrl.sv
`timescale 1ns/1ps
//==========================================================================
// Backup RAM sequencer
// Moves the battery RAM image to and from the SD card one sector at a time,
// with manual load and save, autosave on OSD close and a pending flag
//==========================================================================
`include "sms_settings.svh"

module sms_backup_ctrl
	import sms_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        bk_load_req,
	input  logic        bk_save_req,
	input  logic        autosave,
	input  logic        osd_open,
	input  logic        nvram_we,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        bk_pending
);

	localparam logic [31:0] last_lba = `SMS_BK_SECTORS - 1;

	bk_state_e state;

	logic dl_q;
	logic load_q;
	logic save_q;
	logic ack_q;
	logic bk_ena;
	logic save_cond;
	logic load_go;
	logic save_go;
	logic auto_go;
	logic ack_rise;
	logic ack_fall;

	assign save_cond = bk_save_req | (bk_pending & osd_open & autosave);

	assign load_go  = bk_load_req & bk_ena & ~load_q;
	assign save_go  = save_cond & bk_ena & ~save_q;
	assign auto_go  = dl_q & ~cart_download & (|img_size) & bk_ena;  // Reload after a new cart
	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	assign bk_busy    = (state != BK_IDLE);
	assign bk_loading = (state == BK_LOAD);

	//======================================================================
	// Edge detectors and image enable
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q   <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
			bk_ena <= 1'b0;
		end else begin
			dl_q   <= cart_download;
			load_q <= bk_load_req & bk_ena;
			save_q <= save_cond & bk_ena;
			ack_q  <= sd_ack;

			if (cart_download && !dl_q) bk_ena <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly) bk_ena <= 1'b1;
		end
	end

	//======================================================================
	// Sector sequencer
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state  <= BK_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
		end else begin
			if (ack_rise) begin   // Host took the request
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (auto_go || load_go) begin
						state  <= BK_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
						sd_wr  <= 1'b0;
					end else if (save_go) begin
						state  <= BK_SAVE;
						sd_lba <= '0;
						sd_rd  <= 1'b0;
						sd_wr  <= 1'b1;
					end
				end
				BK_LOAD, BK_SAVE: begin
					if (ack_fall) begin
						if (sd_lba == last_lba) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= (state == BK_LOAD);
							sd_wr  <= (state == BK_SAVE);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	// NVRAM written during play, flushed by the next sequence
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_open && nvram_we) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// One direction at a time
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_rd && sd_wr));

endmodule

// File: sms_host_top.sv
`timescale 1ns/1ps
//==========================================================================
// Master System host glue, top level
// Splits downloads into cart and cheat streams and merges reset and LED
//==========================================================================
`include "sms_settings.svh"

module sms_host_top
	import sms_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     ext_reset,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [7:0]               ioctl_index,
	input  logic [7:0]               ioctl_dout,
	input  logic [`SMS_IOCTL_AW-1:0] ioctl_addr,
	input  logic                     rom_ack,
	input  logic [`SMS_ROM_AW-1:0]   rd_addr,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [63:0]              img_size,
	input  logic                     bk_load_req,
	input  logic                     bk_save_req,
	input  logic                     autosave,
	input  logic                     osd_open,
	input  logic                     nvram_we,
	input  logic                     sd_ack,
	output logic                     ce_cpu,
	output logic                     ce_vdp,
	output logic                     ce_pix,
	output logic                     ce_sp,
	output logic                     ioctl_wait,
	output logic                     rom_wr,
	output logic [`SMS_ROM_AW-1:0]   rom_addr,
	output logic [7:0]               rom_data,
	output logic [`SMS_ROM_AW-1:0]   rd_addr_out,
	output logic                     is_gg,
	output cheat_code_t              code,
	output logic                     code_valid,
	output logic [31:0]              sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     bk_pending,
	output logic                     core_reset,
	output logic                     led
);

	logic code_index;
	logic code_download;
	logic cart_download;
	logic bk_busy;
	logic bk_loading;

	// Download decode
	assign code_index    = (ioctl_index == `SMS_CHEAT_INDEX);
	assign code_download = ioctl_download & code_index;
	assign cart_download = ioctl_download & ~code_index;

	// Core held in reset while the image or its save is loading
	assign core_reset = ext_reset | cart_download | bk_loading;
	assign led        = cart_download | bk_busy | (autosave & bk_pending);

	sms_ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	sms_cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_index   (ioctl_index),
		.ioctl_dout    (ioctl_dout),
		.rom_ack       (rom_ack),
		.rd_addr       (rd_addr),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.rd_addr_out   (rd_addr_out),
		.is_gg         (is_gg)
	);

	sms_cheat_loader u_cheat_loader (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr[3:0]),   // Offset within the record
		.ioctl_dout    (ioctl_dout),
		.code          (code),
		.code_valid    (code_valid)
	);

	sms_backup_ctrl u_backup_ctrl (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.nvram_we      (nvram_we),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps
//==========================================================================
// Testbench clock and reset source
// 40 ns clk_sys, arst_n held low for the first 10 cycles
//==========================================================================

module tb_clk_gen (
	output logic clk_sys,
	output logic arst_n
);

	localparam realtime half_period = 20ns;

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);    // Release away from the active edge
		arst_n = 1'b1;
	end

endmodule

// File: tb_sms_host.sv
`timescale 1ns/1ps
//==========================================================================
// Testbench for the Master System host glue
// ROM and SD card models, reference functions, checker and watchdog
//==========================================================================
`include "sms_settings.svh"

module tb_sms_host
	import sms_pkg::*;
();

	// About 15k cycles of traffic in total, limit leaves margin
	localparam int max_cycles = 20000;
	localparam int n_sectors  = `SMS_BK_SECTORS;

	logic clk_sys, arst_n;
	logic ext_reset, ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [`SMS_IOCTL_AW-1:0] ioctl_addr;
	logic rom_ack;
	logic [`SMS_ROM_AW-1:0] rd_addr;
	logic img_mounted, img_readonly;
	logic [63:0] img_size;
	logic bk_load_req, bk_save_req, autosave, osd_open, nvram_we, sd_ack;
	logic ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic ioctl_wait, rom_wr, is_gg, code_valid;
	logic [`SMS_ROM_AW-1:0] rom_addr, rd_addr_out;
	logic [7:0] rom_data;
	cheat_code_t code;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, bk_pending, core_reset, led;

	logic [7:0]  rom_mem [0:2047];     // Bytes stored by the ROM model
	logic [7:0]  cart_img [0:2047];    // Bytes sent by the loader
	logic        sd_log_wr [$];        // 1 for a write sector
	logic [31:0] sd_log_lba [$];
	cheat_code_t got_code;
	int          valid_cnt;
	int          n_checks;
	int          n_errors;
	int          cycles;
	int unsigned rom_lat;
	int unsigned sd_lat;
	logic        reset_watch;          // Core reset must hold during SD traffic

	tb_clk_gen u_clk_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	sms_host_top u_sms_host_top (.*);

	//======================================================================
	// Checker and reference functions
	//======================================================================
	task automatic check_value(input string name, input logic [127:0] got,
	                           input logic [127:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// Masks rebuilt from the write sequence 0 .. size-1, final address is size
	function automatic logic [`SMS_ROM_AW-1:0] ref_fold(input logic [`SMS_ROM_AW-1:0] ra,
	                                                     input int size);
		logic [`SMS_ROM_AW-1:0] m;
		logic [`SMS_ROM_AW-1:0] m512;
		logic [`SMS_ROM_AW-1:0] a22;
		logic                   hdr;
		int                     a;
		m    = '0;
		m512 = '0;
		for (a = 0; a < size; a++) begin
			a22  = a;
			m    = (a == 0) ? '0 : (m | a22);
			m512 = (a == `SMS_HDR_BYTES) ? '0 : (m512 | (a22 - `SMS_HDR_BYTES));
		end
		hdr = (size / `SMS_HDR_BYTES) % 2;
		return hdr ? ((ra + `SMS_HDR_BYTES) & m512) : (ra & m);
	endfunction

	// Byte n goes to field n/4, byte n mod 4, least significant first
	function automatic cheat_code_t ref_cheat(input logic [127:0] raw);
		logic [31:0] word [0:3];
		cheat_code_t rec;
		int          n;
		for (n = 0; n < 16; n++) word[n / 4][8 * (n % 4) +: 8] = raw[8 * n +: 8];
		rec.flags   = word[0];
		rec.addr    = word[1];
		rec.compare = word[2];
		rec.replace = word[3];
		return rec;
	endfunction

	//======================================================================
	// ROM and SD card models, monitors, watchdog
	//======================================================================
	always begin
		@(negedge clk_sys);
		if (rom_wr !== rom_ack) begin   // New toggle from the loader
			rom_lat = $urandom_range(1, 4);
			repeat (rom_lat - 1) @(negedge clk_sys);
			rom_mem[rom_addr] = rom_data;
			rom_ack = rom_wr;
		end
	end

	always begin
		@(negedge clk_sys);
		if (sd_rd || sd_wr) begin
			sd_log_wr.push_back(sd_wr);
			sd_log_lba.push_back(sd_lba);
			if (reset_watch) check_value("core_reset", core_reset, 1);
			sd_lat = $urandom_range(2, 6);
			repeat (sd_lat) @(negedge clk_sys);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			if (reset_watch) check_value("core_reset", core_reset, 1);
			sd_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		check_value("sd_rd & sd_wr", sd_rd & sd_wr, 0);
		if (code_valid) begin
			valid_cnt++;
			got_code = code;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles == max_cycles) begin
			$display("Timeout after %0d cycles, the run did not finish", max_cycles);
			$display("Checks: %0d, errors: %0d", n_checks, n_errors);
			$display("Something failed");
			$finish;
		end
	end

	//======================================================================
	// Test tasks
	//======================================================================
	task automatic check_ce_strobes;
		int c;
		int last_cpu;
		int n_vdp;
		int n_pix;
		int n_cpu;
		int n_sp;
		last_cpu = -1;
		n_vdp = 0;
		n_pix = 0;
		n_cpu = 0;
		n_sp  = 0;
		for (c = 0; c < 300; c++) begin
			@(negedge clk_sys);
			n_vdp += ce_vdp;
			n_pix += ce_pix;
			n_sp  += ce_sp;
			if (ce_cpu) begin
				n_cpu++;
				check_value("ce_vdp with ce_cpu", ce_vdp, 1);
				if (last_cpu >= 0) check_value("ce_cpu spacing", c - last_cpu, 15);
				last_cpu = c;
			end
		end
		check_value("ce_vdp count", n_vdp, 60);
		check_value("ce_pix count", n_pix, 30);
		check_value("ce_cpu count", n_cpu, 20);
		check_value("ce_sp count", n_sp, 150);
	endtask

	task automatic download_cart(input int size, input logic [7:0] index);
		logic [`SMS_ROM_AW-1:0] ra;
		int                     a;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (a = 0; a < size; a++) begin
			cart_img[a] = $urandom;
			ioctl_addr  = a;
			ioctl_dout  = cart_img[a];
			ioctl_wr    = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			while (ioctl_wait) @(negedge clk_sys);   // Back-pressure
		end
		ioctl_addr = size;
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		for (a = 0; a < size; a++)
			check_value($sformatf("rom_mem[%0d]", a), rom_mem[a], cart_img[a]);
		check_value("is_gg", is_gg, index[4:0] == `SMS_GG_INDEX);
		repeat (16) begin
			@(negedge clk_sys);
			ra = $urandom;
			rd_addr = ra;
			#5;
			check_value("rd_addr_out", rd_addr_out, ref_fold(ra, size));
		end
	endtask

	task automatic download_cheat(input int rec_no);
		logic [127:0] raw;
		int           n;
		ioctl_index    = `SMS_CHEAT_INDEX;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (n = 0; n < 16; n++) begin
			raw[8 * n +: 8] = $urandom;
			ioctl_addr = rec_no * 16 + n;
			ioctl_dout = raw[8 * n +: 8];
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_value("code_valid pulses", valid_cnt, rec_no + 1);
		check_value("code", got_code, ref_cheat(raw));
	endtask

	// All sectors logged and the LED back off
	task automatic wait_backup_done;
		@(negedge clk_sys);
		while (led || sd_log_lba.size() < n_sectors) @(negedge clk_sys);
	endtask

	task automatic check_sectors(input logic exp_wr);
		int i;
		check_value("sector count", sd_log_lba.size(), n_sectors);
		for (i = 0; i < sd_log_lba.size() && i < n_sectors; i++) begin
			check_value($sformatf("sd_wr of sector %0d", i), sd_log_wr[i], exp_wr);
			check_value($sformatf("sd_lba of sector %0d", i), sd_log_lba[i], i);
		end
		sd_log_wr.delete();
		sd_log_lba.delete();
	endtask

	// No image enabled, so requests must stay off the SD port
	task automatic check_disabled_backup;
		bk_load_req = 1'b1;
		bk_save_req = 1'b1;
		nvram_we    = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		repeat (10) begin
			@(negedge clk_sys);
			check_value("sd_rd", sd_rd, 0);
			check_value("sd_wr", sd_wr, 0);
		end
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		check_value("bk_pending", bk_pending, 0);
		ext_reset = 1'b1;
		@(negedge clk_sys);
		check_value("core_reset", core_reset, 1);
		ext_reset = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset", core_reset, 0);
	endtask

	//======================================================================
	// Main sequence
	//======================================================================
	initial begin
		void'($urandom(32'hd791_af6b));
		ext_reset      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_dout     = 8'h00;
		ioctl_addr     = '0;
		rom_ack        = 1'b0;
		rd_addr        = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		osd_open       = 1'b0;
		nvram_we       = 1'b0;
		sd_ack         = 1'b0;
		reset_watch    = 1'b0;
		valid_cnt      = 0;
		n_checks       = 0;
		n_errors       = 0;
		cycles         = 0;
		@(posedge arst_n);

		check_ce_strobes();

		download_cart(1000, 8'h02);
		download_cart(1024, 8'h01);
		download_cart(1536, 8'h22);   // Header case
		check_disabled_backup();

		download_cheat(0);
		download_cheat(1);
		download_cheat(2);

		// Writable image mounted, load follows the download
		img_mounted  = 1'b1;
		img_size     = 64'd8192;
		sd_log_wr.delete();
		sd_log_lba.delete();
		reset_watch  = 1'b1;
		download_cart(64, 8'h01);
		wait_backup_done();
		reset_watch  = 1'b0;
		check_value("core_reset", core_reset, 0);
		check_sectors(1'b0);

		// Manual save
		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		wait_backup_done();
		check_sectors(1'b1);

		// Pending flag and autosave on OSD open
		nvram_we = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		@(negedge clk_sys);
		check_value("bk_pending", bk_pending, 1);
		check_value("led", led, 0);
		autosave = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_value("led", led, 1);
		check_value("sd_wr", sd_wr, 0);
		osd_open = 1'b1;
		wait_backup_done();
		check_sectors(1'b1);
		check_value("bk_pending", bk_pending, 0);
		osd_open = 1'b0;
		autosave = 1'b0;
		repeat (2) @(negedge clk_sys);

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
sms_pkg.sv
sms_ce_gen.sv
sms_cart_loader.sv
sms_cheat_loader.sv
sms_backup_ctrl.sv
sms_host_top.sv
tb_clk_gen.sv
tb_sms_host.sv

// File: Bender.yml
package:
  name: sms_host

export_include_dirs:
  - .

sources:
  - sms_pkg.sv
  - sms_ce_gen.sv
  - sms_cart_loader.sv
  - sms_cheat_loader.sv
  - sms_backup_ctrl.sv
  - sms_host_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_sms_host.sv
